/* bench/acq_framer_sva.sv */
`timescale 1ns/1ps

module acq_framer_sva (
    input logic                   clk,
    input logic                   rst,
    input logic                   wb_ack,
    input logic                   out_valid,
    input logic [7:0]             out_byte,
    input logic                   out_ready,
    input logic                   seq_valid,
    input frame_pkg::frame_byte_t seq_byte,
    input logic                   seq_ready
);

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_byte))
        else $error("out_byte changed while the output was stalled");

    ack_once: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wishbone ack high for two cycles");

    // sequencer held off while the sum goes out
    sum_block: assert property (@(posedge clk) disable iff (rst)
        seq_valid && seq_ready && seq_byte.last |=> !seq_ready)
        else $error("seq_ready high right after the last data byte");

endmodule

bind acq_framer_top acq_framer_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .wb_ack    (wb_ack),
    .out_valid (out_valid),
    .out_byte  (out_byte),
    .out_ready (out_ready),
    .seq_valid (seq_valid),
    .seq_byte  (seq_byte),
    .seq_ready (seq_ready)
);

/* bench/acq_framer_tb.sv */
`timescale 1ns/1ps

module acq_framer_tb;
    import frame_pkg::*;

    localparam int max_cycles = 20000; // several times the longest test

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    cfg_addr_e              wb_adr;
    logic [15:0]            wb_dat_w;
    logic [15:0]            wb_dat_r;
    logic                   wb_ack;
    logic                   sample_valid;
    logic [group_sel_w-1:0] sample_group;
    logic [sample_w-1:0]    sample_data;
    logic                   out_valid;
    logic [7:0]             out_byte;
    logic                   out_ready;

    logic [31:0]            lcg_state = 32'h364d1f85;
    int                     cycle_cnt = 0;
    int                     frames = 0;
    bit                     fail_shown = 1'b0;
    bit                     passed = 1'b0;
    logic [sample_w-1:0]    grp_q [num_groups][$]; // model of the group buffers
    logic [7:0]             exp_q [$];
    dev_cfg_t               cfg_m;

    acq_framer_top dut (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .sample_valid (sample_valid),
        .sample_group (sample_group),
        .sample_data  (sample_data),
        .out_valid    (out_valid),
        .out_byte     (out_byte),
        .out_ready    (out_ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            report_fail("run timed out before all tests finished");
        end
    end

    task automatic report_fail(input string what);
        $display("%s", what);
        fail_shown = 1'b1;
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16]; // upper bits are the better ones
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("mismatch out_byte got %h expected %h", got, exp));
        end
    endtask

    task automatic check_reg(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("mismatch wb_dat_r got %h expected %h", got, exp));
        end
    endtask

    task automatic wb_access(input logic we, input cfg_addr_e adr, input logic [15:0] wdata,
                             output logic [15:0] rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 50) begin
                report_fail("wishbone ack never came");
            end
        end while (!wb_ack);
        rdata  = wb_dat_r; // valid together with ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input cfg_addr_e adr, input logic [15:0] data);
        logic [15:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input cfg_addr_e adr, output logic [15:0] data);
        wb_access(1'b0, adr, 16'h0000, data);
    endtask

    function automatic dev_cfg_t make_cfg(input logic [7:0] en, input logic [7:0] lng);
        dev_cfg_t c;
        c.info       = 8'(next_rand());
        c.rate       = 8'(next_rand());
        c.kind       = 8'(next_rand());
        c.group_en   = en;
        c.group_long = lng;
        return c;
    endfunction

    task automatic write_cfg(input dev_cfg_t c);
        cfg_m = c;
        wb_write(adr_dev_info, {8'h00, c.info});
        wb_write(adr_dev_rate, {8'h00, c.rate});
        wb_write(adr_dev_kind, {8'h00, c.kind});
        wb_write(adr_group_en, {8'h00, c.group_en});
        wb_write(adr_group_long, {8'h00, c.group_long});
    endtask

    task automatic start_frame();
        wb_write(adr_ctrl, 16'h0001);
    endtask

    task automatic drive_sample(input logic [group_sel_w-1:0] g, input logic [sample_w-1:0] d);
        sample_valid = 1'b1;
        sample_group = g;
        sample_data  = d;
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task automatic push_sample(input logic [group_sel_w-1:0] g, input logic [sample_w-1:0] d);
        grp_q[g].push_back(d);
        drive_sample(g, d);
    endtask

    task automatic push_random(input logic [group_sel_w-1:0] g, input int n);
        repeat (n) begin
            push_sample(g, next_rand());
        end
    endtask

    // header, data groups from high index to low, then the sum of data bytes
    task automatic build_frame();
        logic [7:0]          sum;
        logic [sample_w-1:0] w;
        int                  n;
        sum = 8'h00;
        exp_q.delete();
        exp_q.push_back(8'h55);
        exp_q.push_back(8'hAA);
        exp_q.push_back(cfg_m.info);
        exp_q.push_back(cfg_m.rate);
        exp_q.push_back(cfg_m.kind);
        for (int g = num_groups - 1; g >= 0; g--) begin
            if (cfg_m.group_en[g]) begin
                n = cfg_m.group_long[g] ? 16 : 8;
                repeat (n) begin
                    w = grp_q[g].pop_front();
                    exp_q.push_back(w[15:8]);
                    exp_q.push_back(w[7:0]);
                    sum = sum + w[15:8] + w[7:0];
                end
            end
        end
        exp_q.push_back(sum);
    endtask

    task automatic expect_frame(input bit random_ready);
        int          idx;
        logic [15:0] r;
        build_frame();
        idx = 0;
        while (idx < exp_q.size()) begin
            r = next_rand();
            out_ready = random_ready ? (r[0] | r[1]) : 1'b1; // about 3 in 4 when random
            if (out_valid && out_ready) begin
                check_byte(out_byte, exp_q[idx]);
                idx++;
            end
            @(negedge clk);
        end
        out_ready = 1'b0;
        frames++;
        repeat (10) begin
            @(negedge clk);
            if (out_valid) begin
                report_fail("extra byte came out after the end of a frame");
            end
        end
    endtask

    task automatic test_registers();
        logic [15:0] rd;
        logic [7:0]  vals [5];
        wb_read(adr_status, rd);
        check_reg(rd, 16'h0000);
        for (int a = 1; a <= 5; a++) begin
            vals[a-1] = 8'(next_rand());
            wb_write(cfg_addr_e'(a), {8'h00, vals[a-1]});
        end
        for (int a = 1; a <= 5; a++) begin
            wb_read(cfg_addr_e'(a), rd);
            check_reg(rd, {8'h00, vals[a-1]});
        end
    endtask

    task automatic test_single_group();
        write_cfg(make_cfg(8'h04, 8'h00)); // group 2 short
        push_random(2, 8);
        start_frame();
        expect_frame(1'b0);
    endtask

    task automatic test_mixed(input bit random_ready);
        write_cfg(make_cfg(8'h91, 8'h10)); // groups 7, 4, 0 with 4 long
        push_random(7, 8);
        push_random(4, 16);
        push_random(0, 8);
        start_frame();
        expect_frame(random_ready);
    endtask

    // frame waits in the data section until the samples arrive
    task automatic test_stall();
        logic [sample_w-1:0] d [8];
        write_cfg(make_cfg(8'h20, 8'h00));
        for (int i = 0; i < 8; i++) begin
            d[i] = next_rand();
            grp_q[5].push_back(d[i]);
        end
        start_frame();
        fork
            expect_frame(1'b0);
            begin
                repeat (40) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    drive_sample(5, d[i]);
                end
            end
        join
    endtask

    task automatic test_header_only();
        write_cfg(make_cfg(8'h00, 8'h00)); // header only, sum 00
        start_frame();
        expect_frame(1'b0);
    endtask

    // second start lands while the first frame is stalled
    task automatic test_busy_start();
        write_cfg(make_cfg(8'h02, 8'h02));
        push_random(1, 16);
        start_frame();
        repeat (3) @(negedge clk);
        start_frame(); // busy, must be ignored
        expect_frame(1'b1);
    endtask

    task automatic test_status();
        logic [15:0] rd;
        wb_read(adr_status, rd);
        check_reg(rd, {8'(frames), 7'd0, 1'b0});
    endtask

    initial begin
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = adr_ctrl;
        wb_dat_w     = 16'h0000;
        sample_valid = 1'b0;
        sample_group = '0;
        sample_data  = '0;
        out_ready    = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        test_registers();
        test_single_group();
        test_mixed(1'b0);
        test_mixed(1'b1);
        test_stall();
        test_header_only();
        test_busy_start();
        test_status();

        passed = 1'b1;
        $display("NO ERRORS");
        $finish;
    end

    final begin
        if (!passed && !fail_shown) begin
            $display("ERRORS FOUND");
        end
    end

endmodule

/* flist.f */
hw/frame_pkg.sv
hw/cfg_regs.sv
hw/group_buffer.sv
hw/frame_sequencer.sv
hw/frame_checksum.sv
hw/acq_framer_top.sv
bench/acq_framer_sva.sv
bench/acq_framer_tb.sv

/* hw/acq_framer_top.sv */
`timescale 1ns/1ps

module acq_framer_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  frame_pkg::cfg_addr_e              wb_adr,
    input  logic [15:0]                       wb_dat_w,
    output logic [15:0]                       wb_dat_r,
    output logic                              wb_ack,
    input  logic                              sample_valid,
    input  logic [frame_pkg::group_sel_w-1:0] sample_group,
    input  logic [frame_pkg::sample_w-1:0]    sample_data,
    output logic                              out_valid,
    output logic [7:0]                        out_byte,
    input  logic                              out_ready
);
    import frame_pkg::*;

    dev_cfg_t              cfg;
    logic                  start;
    logic                  busy;
    logic                  frame_done;
    logic [num_groups-1:0] grp_wr;
    logic [num_groups-1:0] grp_pop;
    logic [num_groups-1:0] grp_empty;
    logic [sample_w-1:0]   grp_head [num_groups];
    logic                  seq_valid;
    logic                  seq_ready;
    frame_byte_t           seq_byte;

    assign grp_wr = sample_valid ? (num_groups'(1) << sample_group) : '0;

    cfg_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .cfg        (cfg),
        .start      (start),
        .busy       (busy),
        .frame_done (frame_done)
    );

    for (genvar g = 0; g < num_groups; g++) begin : g_buf
        group_buffer u_buf (
            .clk     (clk),
            .rst     (rst),
            .wr      (grp_wr[g]),
            .wr_data (sample_data),
            .pop     (grp_pop[g]),
            .empty   (grp_empty[g]),
            .head    (grp_head[g])
        );
    end

    frame_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .cfg        (cfg),
        .grp_empty  (grp_empty),
        .grp_head   (grp_head),
        .grp_pop    (grp_pop),
        .seq_valid  (seq_valid),
        .seq_byte   (seq_byte),
        .seq_ready  (seq_ready),
        .busy       (busy),
        .frame_done (frame_done)
    );

    frame_checksum u_csum (
        .clk       (clk),
        .rst       (rst),
        .seq_valid (seq_valid),
        .seq_byte  (seq_byte),
        .seq_ready (seq_ready),
        .out_valid (out_valid),
        .out_byte  (out_byte),
        .out_ready (out_ready)
    );

endmodule

/* hw/cfg_regs.sv */
`timescale 1ns/1ps

module cfg_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  frame_pkg::cfg_addr_e wb_adr,
    input  logic [15:0]         wb_dat_w,
    output logic [15:0]         wb_dat_r,
    output logic                wb_ack,
    output frame_pkg::dev_cfg_t cfg,
    output logic                start,
    input  logic                busy,
    input  logic                frame_done
);
    import frame_pkg::*;

    logic       req;
    logic       wr_en;
    logic [7:0] frame_cnt;
    logic [15:0] rd_data;

    assign req   = wb_cyc & wb_stb & ~wb_ack; // no second ack on a held request
    assign wr_en = req & wb_we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            start     <= 1'b0;
            cfg       <= '0;
            frame_cnt <= '0;
        end else begin
            wb_ack <= req;
            start  <= wr_en && wb_adr == adr_ctrl && wb_dat_w[0] && !busy;
            if (wr_en) begin
                case (wb_adr)
                    adr_dev_info:   cfg.info       <= wb_dat_w[7:0];
                    adr_dev_rate:   cfg.rate       <= wb_dat_w[7:0];
                    adr_dev_kind:   cfg.kind       <= wb_dat_w[7:0];
                    adr_group_en:   cfg.group_en   <= wb_dat_w[7:0];
                    adr_group_long: cfg.group_long <= wb_dat_w[7:0];
                    default: ;
                endcase
            end
            if (frame_done) begin
                frame_cnt <= frame_cnt + 8'd1; // wraps
            end
        end
    end

    always_comb begin
        case (wb_adr)
            adr_dev_info:   rd_data = {8'h00, cfg.info};
            adr_dev_rate:   rd_data = {8'h00, cfg.rate};
            adr_dev_kind:   rd_data = {8'h00, cfg.kind};
            adr_group_en:   rd_data = {8'h00, cfg.group_en};
            adr_group_long: rd_data = {8'h00, cfg.group_long};
            adr_status:     rd_data = {frame_cnt, 7'd0, busy};
            default:        rd_data = 16'h0000;
        endcase
    end

    // read data lands together with ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

/* hw/frame_checksum.sv */
`timescale 1ns/1ps

module frame_checksum (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   seq_valid,
    input  frame_pkg::frame_byte_t seq_byte,
    output logic                   seq_ready,
    output logic                   out_valid,
    output logic [7:0]             out_byte,
    input  logic                   out_ready
);
    import frame_pkg::*;

    logic [7:0] sum;
    logic       sum_pend; // sum byte still to be sent
    logic       out_free;
    logic       seq_fire;

    assign out_free  = ~out_valid | out_ready;
    assign seq_ready = out_free & ~sum_pend;
    assign seq_fire  = seq_valid & seq_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            sum_pend  <= 1'b0;
            sum       <= '0;
        end else if (out_free) begin
            if (sum_pend) begin
                out_valid <= 1'b1;
                sum_pend  <= 1'b0;
                sum       <= '0; // ready for next frame
            end else if (seq_fire) begin
                out_valid <= 1'b1;
                sum_pend  <= seq_byte.last;
                if (seq_byte.is_data) begin
                    sum <= sum + seq_byte.data;
                end
            end else begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (sum_pend) begin
                out_byte <= sum;
            end else if (seq_fire) begin
                out_byte <= seq_byte.data;
            end
        end
    end

endmodule

/* hw/frame_pkg.sv */
package frame_pkg;

    localparam int num_groups  = 8;
    localparam int group_sel_w = 3;
    localparam int sample_w    = 16;

    localparam int buf_depth = 32;
    localparam int buf_ptr_w = $clog2(buf_depth);

    localparam int short_words = 8;
    localparam int long_words  = 16;
    localparam int word_cnt_w  = $clog2(long_words); // word index within a group

    localparam logic [7:0] sync0 = 8'h55;
    localparam logic [7:0] sync1 = 8'hAA;

    typedef enum logic [3:0] {
        st_idle,
        st_sync0,
        st_sync1,
        st_info,
        st_rate,
        st_kind,
        st_pick, // find next enabled group
        st_hi,
        st_lo,
        st_end
    } frame_state_e;

    // wishbone word addresses
    typedef enum logic [2:0] {
        adr_ctrl       = 3'd0,
        adr_dev_info   = 3'd1,
        adr_dev_rate   = 3'd2,
        adr_dev_kind   = 3'd3,
        adr_group_en   = 3'd4,
        adr_group_long = 3'd5,
        adr_status     = 3'd6
    } cfg_addr_e;

    typedef struct packed {
        logic [7:0] info;
        logic [7:0] rate;
        logic [7:0] kind;
        logic [7:0] group_en;   // one bit per group
        logic [7:0] group_long; // 1 = long group
    } dev_cfg_t;

    typedef struct packed {
        logic [7:0] data;
        logic       is_data; // counted in checksum
        logic       last;    // end of data section
    } frame_byte_t;

endpackage

/* hw/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  frame_pkg::dev_cfg_t               cfg,
    input  logic [frame_pkg::num_groups-1:0]  grp_empty,
    input  logic [frame_pkg::sample_w-1:0]    grp_head [frame_pkg::num_groups],
    output logic [frame_pkg::num_groups-1:0]  grp_pop,
    output logic                              seq_valid,
    output frame_pkg::frame_byte_t            seq_byte,
    input  logic                              seq_ready,
    output logic                              busy,
    output logic                              frame_done
);
    import frame_pkg::*;

    frame_state_e            state;
    dev_cfg_t                cfg_q;
    logic [group_sel_w-1:0]  grp_idx;
    logic [word_cnt_w-1:0]   word_cnt;
    logic [word_cnt_w-1:0]   words_m1;
    logic [num_groups-1:0]   lower_mask;
    logic                    lower_en;
    logic                    last_word;
    logic                    seq_fire;
    logic [sample_w-1:0]     cur_head;

    assign cur_head   = grp_head[grp_idx];
    assign words_m1   = cfg_q.group_long[grp_idx] ? word_cnt_w'(long_words - 1)
                                                  : word_cnt_w'(short_words - 1);
    assign lower_mask = (num_groups'(1) << grp_idx) - 1'b1;
    assign lower_en   = |(cfg_q.group_en & lower_mask); // more groups below this one
    assign last_word  = word_cnt == words_m1;
    assign seq_fire   = seq_valid & seq_ready;

    assign busy       = state != st_idle;
    assign frame_done = state == st_end;
    assign grp_pop    = (state == st_lo && seq_ready) ? (num_groups'(1) << grp_idx) : '0;

    always_comb begin
        seq_valid        = 1'b1;
        seq_byte.data    = 8'h00;
        seq_byte.is_data = 1'b0;
        seq_byte.last    = 1'b0;
        case (state)
            st_sync0: seq_byte.data = sync0;
            st_sync1: seq_byte.data = sync1;
            st_info:  seq_byte.data = cfg_q.info;
            st_rate:  seq_byte.data = cfg_q.rate;
            st_kind: begin
                seq_byte.data = cfg_q.kind;
                seq_byte.last = cfg_q.group_en == '0; // header only frame
            end
            st_hi: begin
                seq_valid        = ~grp_empty[grp_idx]; // wait for samples
                seq_byte.data    = cur_head[15:8];
                seq_byte.is_data = 1'b1;
            end
            st_lo: begin
                seq_byte.data    = cur_head[7:0];
                seq_byte.is_data = 1'b1;
                seq_byte.last    = last_word & ~lower_en;
            end
            default: seq_valid = 1'b0; // idle, pick, end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            cfg_q    <= '0;
            grp_idx  <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        cfg_q <= cfg;
                        state <= st_sync0;
                    end
                end
                st_sync0: begin
                    if (seq_fire) begin
                        state <= st_sync1;
                    end
                end
                st_sync1: begin
                    if (seq_fire) begin
                        state <= st_info;
                    end
                end
                st_info: begin
                    if (seq_fire) begin
                        state <= st_rate;
                    end
                end
                st_rate: begin
                    if (seq_fire) begin
                        state <= st_kind;
                    end
                end
                st_kind: begin
                    if (seq_fire) begin
                        if (cfg_q.group_en == '0) begin
                            state <= st_end;
                        end else begin
                            state   <= st_pick;
                            grp_idx <= group_sel_w'(num_groups - 1);
                        end
                    end
                end
                st_pick: begin
                    if (cfg_q.group_en[grp_idx]) begin
                        state    <= st_hi;
                        word_cnt <= '0;
                    end else begin
                        grp_idx <= grp_idx - 1'b1;
                    end
                end
                st_hi: begin
                    if (seq_fire) begin
                        state <= st_lo;
                    end
                end
                st_lo: begin
                    if (seq_fire) begin
                        if (!last_word) begin
                            state    <= st_hi;
                            word_cnt <= word_cnt + 1'b1;
                        end else if (lower_en) begin
                            state   <= st_pick;
                            grp_idx <= grp_idx - 1'b1;
                        end else begin
                            state <= st_end;
                        end
                    end
                end
                default: state <= st_idle; // st_end
            endcase
        end
    end

endmodule

/* hw/group_buffer.sv */
`timescale 1ns/1ps

module group_buffer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr,
    input  logic [frame_pkg::sample_w-1:0] wr_data,
    input  logic                           pop,
    output logic                           empty,
    output logic [frame_pkg::sample_w-1:0] head
);
    import frame_pkg::*;

    logic [sample_w-1:0]  mem [buf_depth];
    logic [buf_ptr_w-1:0] wr_ptr;
    logic [buf_ptr_w-1:0] rd_ptr;
    logic [buf_ptr_w:0]   count;
    logic                 full;
    logic                 push;

    assign full  = count == (buf_ptr_w + 1)'(buf_depth);
    assign empty = count == '0;
    assign push  = wr & ~full; // dropped when full
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f flist.f --top-module acq_framer_tb -Mdir obj_dir

sim_out=$(./obj_dir/Vacq_framer_tb || true)
echo "$sim_out"

if grep -qx "NO ERRORS" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
